/* proc.f */
+incdir+include
verilog/procPkg.sv
verilog/fetch.sv
verilog/control.sv
verilog/decode.sv
verilog/execute.sv
verilog/memWriteback.sv
verilog/proc.sv
verif/procTb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, pass only if TEST OK is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f proc.f --top-module procTb -o procSim || exit 1

simOut="$(./obj_dir/procSim)"
printf '%s\n' "$simOut"

printf '%s\n' "$simOut" | grep -qx "TEST OK" && exit 0 || exit 1

/* include/procTbTasks.svh */
task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
   if (actual !== expected)
   begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "Value mismatch");
   end
endtask

function automatic logic [15:0] encodeReg(procPkg::opcodeT op, int rd, int rs, int rt);
   return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
endfunction

function automatic logic [15:0] encodeImm6(procPkg::opcodeT op, int rd, int rs, int imm);
   return {op, rd[2:0], rs[2:0], imm[5:0]};
endfunction

function automatic logic [15:0] encodeImm9(procPkg::opcodeT op, int rd, int imm);
   return {op, rd[2:0], imm[8:0]};
endfunction

function automatic logic [15:0] encodeJump(int offset);
   return {procPkg::opJ, offset[11:0]};
endfunction

function automatic logic [15:0] signExt9(logic [8:0] v);
   return {{7{v[8]}}, v};
endfunction

function automatic logic [15:0] signExt6(logic [5:0] v);
   return {{10{v[5]}}, v};
endfunction

task automatic expectRetire(int pc, logic regWrite, int wrReg, logic [15:0] wrData);
   procPkg::retireT entry;
   entry.valid    = 1'b1;
   entry.pc       = pc[15:0];
   entry.regWrite = regWrite;
   entry.wrReg    = wrReg[2:0];
   entry.wrData   = wrData;
   expQ.push_back(entry);
endtask

// Load progQ under reset, then record retires until the halt latch sets
task automatic runProgram();
   int  loadCycles;
   bit  done;
   gotQ.delete();
   loadCycles = (progQ.size() > 16) ? progQ.size() : 16;
   for (int i = 0; i < loadCycles; i++)
   begin
      @(posedge clk);
      rst <= 1'b1;
      if (i < progQ.size())
      begin
         load.en   <= 1'b1;
         load.addr <= i[7:0];
         load.data <= progQ[i];
      end
      else
      begin
         load <= '0;
      end
   end
   @(posedge clk);
   load <= '0;
   rst  <= 1'b0;
   done = 1'b0;
   while (!done)
   begin
      @(negedge clk);
      if (halted)
      begin
         done = 1'b1;
      end
      else if (retire.valid)
      begin
         gotQ.push_back(retire);
      end
   end
endtask

task automatic compareTrace(string testName);
   checkValue({testName, " retire count"}, gotQ.size(), expQ.size());
   for (int i = 0; i < expQ.size(); i++)
   begin
      checkValue($sformatf("%s retire.pc[%0d]", testName, i), gotQ[i].pc, expQ[i].pc);
      checkValue($sformatf("%s retire.regWrite[%0d]", testName, i),
                 gotQ[i].regWrite, expQ[i].regWrite);
      // Destination only matters when a register is written
      if (expQ[i].regWrite)
      begin
         checkValue($sformatf("%s retire.wrReg[%0d]", testName, i),
                    gotQ[i].wrReg, expQ[i].wrReg);
         checkValue($sformatf("%s retire.wrData[%0d]", testName, i),
                    gotQ[i].wrData, expQ[i].wrData);
      end
   end
   checkValue({testName, " retire.valid once halted"}, retire.valid, 1'b0);
endtask

task automatic testArithmetic();
   logic [8:0]  a;
   logic [8:0]  b;
   logic [5:0]  imm;
   logic [15:0] r1;
   logic [15:0] r2;
   a   = 9'($urandom());
   b   = 9'($urandom());
   imm = 6'($urandom());
   r1  = signExt9(a);
   r2  = signExt9(b);
   progQ.delete();
   expQ.delete();
   progQ.push_back(encodeImm9(procPkg::opLbi, 1, a));
   progQ.push_back(encodeImm9(procPkg::opLbi, 2, b));
   progQ.push_back(encodeReg(procPkg::opAdd, 3, 1, 2));
   progQ.push_back(encodeReg(procPkg::opSub, 4, 1, 2));
   progQ.push_back(encodeReg(procPkg::opAnd, 5, 1, 2));
   progQ.push_back(encodeReg(procPkg::opXor, 6, 1, 2));
   progQ.push_back(encodeImm6(procPkg::opAddi, 7, 1, imm));
   progQ.push_back({procPkg::opHalt, 12'h000});
   expectRetire(0, 1'b1, 1, r1);
   expectRetire(1, 1'b1, 2, r2);
   expectRetire(2, 1'b1, 3, r1 + r2);
   expectRetire(3, 1'b1, 4, r1 - r2);
   expectRetire(4, 1'b1, 5, r1 & r2);
   expectRetire(5, 1'b1, 6, r1 ^ r2);
   expectRetire(6, 1'b1, 7, r1 + signExt6(imm));
   expectRetire(7, 1'b0, 0, 16'h0000);
   runProgram();
   compareTrace("arithmetic");
endtask

task automatic testConstBuild();
   logic [15:0] k1;
   logic [15:0] k2;
   logic [15:0] hi1;
   logic [15:0] hi2;
   k1  = 16'($urandom());
   k2  = 16'($urandom());
   // High byte goes through LBI with its sign bit on top
   hi1 = signExt9({k1[15], k1[15:8]});
   hi2 = signExt9({k2[15], k2[15:8]});
   progQ.delete();
   expQ.delete();
   progQ.push_back(encodeImm9(procPkg::opLbi, 1, {k1[15], k1[15:8]}));
   progQ.push_back(encodeImm9(procPkg::opSlbi, 1, {1'b0, k1[7:0]}));
   progQ.push_back(encodeImm9(procPkg::opLbi, 5, {k2[15], k2[15:8]}));
   progQ.push_back(encodeImm9(procPkg::opSlbi, 5, {1'b0, k2[7:0]}));
   progQ.push_back({procPkg::opHalt, 12'h000});
   expectRetire(0, 1'b1, 1, hi1);
   expectRetire(1, 1'b1, 1, (hi1 << 8) | {8'h00, k1[7:0]});
   expectRetire(2, 1'b1, 5, hi2);
   expectRetire(3, 1'b1, 5, (hi2 << 8) | {8'h00, k2[7:0]});
   expectRetire(4, 1'b0, 0, 16'h0000);
   runProgram();
   compareTrace("constant build");
   checkValue("constant r1", gotQ[1].wrData, k1);
   checkValue("constant r5", gotQ[3].wrData, k2);
endtask

task automatic testMemory();
   logic [15:0] v1;
   logic [15:0] v2;
   int          base;
   int          off1;
   int          off2;
   v1   = 16'($urandom());
   v2   = 16'($urandom());
   base = $urandom() % 200;
   off1 = $urandom() % 16;
   off2 = 16 + $urandom() % 16;
   progQ.delete();
   expQ.delete();
   progQ.push_back(encodeImm9(procPkg::opLbi, 1, {v1[15], v1[15:8]}));
   progQ.push_back(encodeImm9(procPkg::opSlbi, 1, {1'b0, v1[7:0]}));
   progQ.push_back(encodeImm9(procPkg::opLbi, 2, {v2[15], v2[15:8]}));
   progQ.push_back(encodeImm9(procPkg::opSlbi, 2, {1'b0, v2[7:0]}));
   progQ.push_back(encodeImm9(procPkg::opLbi, 3, base));
   progQ.push_back(encodeImm6(procPkg::opSt, 1, 3, off1));
   progQ.push_back(encodeImm6(procPkg::opSt, 2, 3, off2));
   progQ.push_back(encodeImm6(procPkg::opLd, 4, 3, off1));
   progQ.push_back(encodeImm6(procPkg::opLd, 5, 3, off2));
   progQ.push_back({procPkg::opHalt, 12'h000});
   expectRetire(0, 1'b1, 1, signExt9({v1[15], v1[15:8]}));
   expectRetire(1, 1'b1, 1, v1);
   expectRetire(2, 1'b1, 2, signExt9({v2[15], v2[15:8]}));
   expectRetire(3, 1'b1, 2, v2);
   expectRetire(4, 1'b1, 3, base[15:0]);
   expectRetire(5, 1'b0, 0, 16'h0000);
   expectRetire(6, 1'b0, 0, 16'h0000);
   expectRetire(7, 1'b1, 4, v1);
   expectRetire(8, 1'b1, 5, v2);
   expectRetire(9, 1'b0, 0, 16'h0000);
   runProgram();
   compareTrace("memory");
endtask

// Path 0 1 2 -> 6 7 8 -> 3 4 5
task automatic testBranches();
   progQ.delete();
   expQ.delete();
   progQ.push_back(encodeImm9(procPkg::opLbi, 1, 0));
   progQ.push_back(encodeImm9(procPkg::opLbi, 2, 5));
   progQ.push_back(encodeImm9(procPkg::opBeqz, 1, 3));
   progQ.push_back(encodeImm9(procPkg::opBnez, 1, 7));
   progQ.push_back(encodeImm9(procPkg::opBeqz, 2, 7));
   progQ.push_back({procPkg::opHalt, 12'h000});
   progQ.push_back(encodeImm9(procPkg::opLbi, 3, 1));
   progQ.push_back(encodeImm9(procPkg::opBeqz, 3, 4));
   progQ.push_back(encodeImm9(procPkg::opBnez, 2, -6));
   expectRetire(0, 1'b1, 1, 16'h0000);
   expectRetire(1, 1'b1, 2, 16'h0005);
   expectRetire(2, 1'b0, 0, 16'h0000);
   expectRetire(2 + 1 + 3, 1'b1, 3, 16'h0001);
   expectRetire(7, 1'b0, 0, 16'h0000);
   expectRetire(8, 1'b0, 0, 16'h0000);
   expectRetire(8 + 1 - 6, 1'b0, 0, 16'h0000);
   expectRetire(4, 1'b0, 0, 16'h0000);
   expectRetire(5, 1'b0, 0, 16'h0000);
   runProgram();
   compareTrace("branches");
endtask

task automatic testJumpHalt();
   progQ.delete();
   expQ.delete();
   progQ.push_back(encodeImm9(procPkg::opLbi, 1, 3));
   progQ.push_back(encodeJump(2));
   progQ.push_back(encodeImm9(procPkg::opLbi, 1, 7));
   progQ.push_back({procPkg::opHalt, 12'h000});
   progQ.push_back(encodeImm6(procPkg::opAddi, 2, 1, 1));
   progQ.push_back(encodeJump(-4));
   expectRetire(0, 1'b1, 1, 16'h0003);
   expectRetire(1, 1'b0, 0, 16'h0000);
   expectRetire(1 + 1 + 2, 1'b1, 2, 16'h0004);
   expectRetire(5, 1'b0, 0, 16'h0000);
   expectRetire(5 + 1 - 4, 1'b1, 1, 16'h0007);
   expectRetire(3, 1'b0, 0, 16'h0000);
   runProgram();
   compareTrace("jump and halt");
   // Core must stay quiet once halted
   repeat (10)
   begin
      @(negedge clk);
      checkValue("retire.valid after halt", retire.valid, 1'b0);
      checkValue("halted after halt", halted, 1'b1);
      checkValue("err after halt", err, 1'b0);
   end
endtask

task automatic testIllegal();
   progQ.delete();
   expQ.delete();
   progQ.push_back(encodeReg(procPkg::opAdd, 1, 0, 0));
   progQ.push_back({4'd14, 3'd2, 9'h000});
   progQ.push_back(encodeImm9(procPkg::opLbi, 2, 5));
   expectRetire(0, 1'b1, 1, 16'h0000);
   expectRetire(1, 1'b0, 0, 16'h0000);
   runProgram();
   compareTrace("illegal opcode");
   repeat (3)
   begin
      @(negedge clk);
      checkValue("err after illegal", err, 1'b1);
      checkValue("halted after illegal", halted, 1'b1);
   end
   @(posedge clk);
   rst <= 1'b1;
   repeat (2) @(posedge clk);
   @(negedge clk);
   checkValue("err after reset", err, 1'b0);
   checkValue("halted after reset", halted, 1'b0);
   checkValue("retire.valid in reset", retire.valid, 1'b0);
   checkValue("retire.pc in reset", retire.pc, 16'h0000);
endtask

/* verif/procTb.sv */
module procTb;

   // Cycle budget per test covers reset, load, retires and a post-halt watch
   localparam int testCount  = 6;
   localparam int progLenMax = 10;
   localparam int retireMax  = 10;
   localparam int cycleLimit = 16 + testCount * (16 + 4 * progLenMax + retireMax + 10) + 100;

   logic            clk;
   logic            rst;
   procPkg::loadT   load;
   procPkg::retireT retire;
   logic            halted;
   logic            err;

   logic [15:0]     progQ [$];
   procPkg::retireT expQ [$];
   procPkg::retireT gotQ [$];
   int              cycleCount = 0;

   proc proc_inst (
      .clk    (clk),
      .rst    (rst),
      .load   (load),
      .retire (retire),
      .halted (halted),
      .err    (err)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #20 clk = ~clk;
      end
   end

   // Guards against a program that never halts
   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit)
      begin
         $display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
         $display("TEST FAILED");
         $fatal(1, "Simulation stopped on timeout");
      end
   end

   `include "procTbTasks.svh"

   initial
   begin
      void'($urandom(66903));
      rst  = 1'b1;
      load = '0;
      repeat (16) @(posedge clk);

      testArithmetic();
      testConstBuild();
      testMemory();
      testBranches();
      testJumpHalt();
      testIllegal();

      $display("TEST OK");
      $finish;
   end

endmodule

/* verilog/proc.sv */
module proc (
   input  logic             clk,
   input  logic             rst,
   input  procPkg::loadT    load,
   output procPkg::retireT  retire,
   output logic             halted,
   output logic             err
);

   logic [procPkg::dataWidth-1:0] pc;
   logic [procPkg::dataWidth-1:0] instr;
   logic [procPkg::dataWidth-1:0] nextPc;
   logic [procPkg::dataWidth-1:0] rsData;
   logic [procPkg::dataWidth-1:0] rdData;
   logic [procPkg::dataWidth-1:0] rtData;
   logic [procPkg::dataWidth-1:0] immVal;
   logic [procPkg::dataWidth-1:0] aluOut;
   logic [procPkg::dataWidth-1:0] wbData;
   procPkg::ctrlT                 ctrl;
   logic                          stop;

   fetch fetchInst (
      .clk    (clk),
      .rst    (rst),
      .load   (load),
      .nextPc (nextPc),
      .stop   (stop),
      .pc     (pc),
      .instr  (instr),
      .halted (halted)
   );

   control controlInst (
      .clk   (clk),
      .rst   (rst),
      .instr (instr),
      .ctrl  (ctrl),
      .stop  (stop),
      .err   (err)
   );

   decode decodeInst (
      .clk    (clk),
      .rst    (rst),
      .instr  (instr),
      .ctrl   (ctrl),
      .wrEn   (ctrl.regWrite),
      .wrData (wbData),
      .rsData (rsData),
      .rdData (rdData),
      .rtData (rtData),
      .immVal (immVal)
   );

   execute executeInst (
      .pc     (pc),
      .ctrl   (ctrl),
      .rsData (rsData),
      .rdData (rdData),
      .immVal (immVal),
      .rtData (rtData),
      .aluOut (aluOut),
      .nextPc (nextPc)
   );

   memWriteback memWritebackInst (
      .clk    (clk),
      .ctrl   (ctrl),
      .aluOut (aluOut),
      .rdData (rdData),
      .wbData (wbData)
   );

   // One retire per cycle out of reset until the halt latch is set
   always_comb
   begin
      retire.valid    = !halted && !rst;
      retire.pc       = pc;
      retire.regWrite = ctrl.regWrite;
      retire.wrReg    = instr[procPkg::rdMsb:procPkg::rdLsb];
      retire.wrData   = wbData;
   end

endmodule

/* verilog/memWriteback.sv */
module memWriteback (
   input  logic                          clk,
   input  procPkg::ctrlT                 ctrl,
   input  logic [procPkg::dataWidth-1:0] aluOut,
   input  logic [procPkg::dataWidth-1:0] rdData,
   output logic [procPkg::dataWidth-1:0] wbData
);

   logic [procPkg::dataWidth-1:0]     dmem [procPkg::dmemDepth];
   logic [procPkg::dmemAddrWidth-1:0] memAddr;
   logic [procPkg::dataWidth-1:0]     memData;

   // Word address from the low bits of the effective address
   assign memAddr = aluOut[procPkg::dmemAddrWidth-1:0];

   // Store data comes from rd
   always_ff @(posedge clk)
   begin
      if (ctrl.memWrite)
      begin
         dmem[memAddr] <= rdData;
      end
   end

   always_comb
   begin
      if (ctrl.memRead)
      begin
         memData = dmem[memAddr];
      end
      else
      begin
         memData = '0;
      end
   end

   // Write-back select
   always_comb
   begin
      if (ctrl.memToReg)
      begin
         wbData = memData;
      end
      else
      begin
         wbData = aluOut;
      end
   end

endmodule

/* verilog/execute.sv */
module execute (
   input  logic [procPkg::dataWidth-1:0] pc,
   input  procPkg::ctrlT                 ctrl,
   input  logic [procPkg::dataWidth-1:0] rsData,
   input  logic [procPkg::dataWidth-1:0] rdData,
   input  logic [procPkg::dataWidth-1:0] immVal,
   input  logic [procPkg::dataWidth-1:0] rtData,
   output logic [procPkg::dataWidth-1:0] aluOut,
   output logic [procPkg::dataWidth-1:0] nextPc
);

   logic [procPkg::dataWidth-1:0] opB;
   logic [procPkg::dataWidth-1:0] pcPlus1;
   logic                          rdIsZero;
   logic                          redirect;

   // Second operand is the immediate or rt
   assign opB = ctrl.aluSrcImm ? immVal : rtData;

   always_comb
   begin
      case (ctrl.aluOp)
         procPkg::aluAdd:
            aluOut = rsData + opB;
         procPkg::aluSub:
            aluOut = rsData - opB;
         procPkg::aluAnd:
            aluOut = rsData & opB;
         procPkg::aluXor:
            aluOut = rsData ^ opB;
         // SLBI works on rd, not rs
         procPkg::aluShiftOr:
            aluOut = (rdData << 8) | opB;
         default:
            aluOut = opB;
      endcase
   end

   assign rdIsZero = (rdData == '0);

   // Branch taken or unconditional jump
   assign redirect = ctrl.jump
                   | (ctrl.branchZero && rdIsZero)
                   | (ctrl.branchNonZero && !rdIsZero);

   assign pcPlus1 = pc + 1'b1;

   // Offsets are relative to the following instruction
   always_comb
   begin
      if (redirect)
      begin
         nextPc = pcPlus1 + immVal;
      end
      else
      begin
         nextPc = pcPlus1;
      end
   end

endmodule

/* verilog/decode.sv */
module decode (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [procPkg::dataWidth-1:0] instr,
   input  procPkg::ctrlT                 ctrl,
   input  logic                          wrEn,
   input  logic [procPkg::dataWidth-1:0] wrData,
   output logic [procPkg::dataWidth-1:0] rsData,
   output logic [procPkg::dataWidth-1:0] rdData,
   output logic [procPkg::dataWidth-1:0] rtData,
   output logic [procPkg::dataWidth-1:0] immVal
);

   logic [procPkg::dataWidth-1:0]   regs [procPkg::regCount];
   logic [procPkg::regIdxWidth-1:0] rdIdx;
   logic [procPkg::regIdxWidth-1:0] rsIdx;
   logic [procPkg::regIdxWidth-1:0] rtIdx;

   assign rdIdx = instr[procPkg::rdMsb:procPkg::rdLsb];
   assign rsIdx = instr[procPkg::rsMsb:procPkg::rsLsb];
   assign rtIdx = instr[procPkg::rtMsb:procPkg::rtLsb];

   // Write port always targets the rd field
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < procPkg::regCount; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (wrEn)
      begin
         regs[rdIdx] <= wrData;
      end
   end

   // Combinational reads
   assign rsData = regs[rsIdx];
   assign rdData = regs[rdIdx];
   assign rtData = regs[rtIdx];

   always_comb
   begin
      case (ctrl.immKind)
         procPkg::imm9Signed:
            immVal = {{(procPkg::dataWidth-procPkg::imm9Msb-1){instr[procPkg::imm9Msb]}},
                      instr[procPkg::imm9Msb:0]};
         // SLBI only uses the low byte, zero extended
         procPkg::imm9Low8:
            immVal = {{(procPkg::dataWidth-8){1'b0}}, instr[7:0]};
         procPkg::imm12Signed:
            immVal = {{(procPkg::dataWidth-procPkg::imm12Msb-1){instr[procPkg::imm12Msb]}},
                      instr[procPkg::imm12Msb:0]};
         default:
            immVal = {{(procPkg::dataWidth-procPkg::imm6Msb-1){instr[procPkg::imm6Msb]}},
                      instr[procPkg::imm6Msb:0]};
      endcase
   end

endmodule

/* verilog/control.sv */
module control (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [procPkg::dataWidth-1:0] instr,
   output procPkg::ctrlT                 ctrl,
   output logic                          stop,
   output logic                          err
);

   procPkg::opcodeT opcode;
   logic            illegal;

   assign opcode = procPkg::opcodeT'(instr[procPkg::opMsb:procPkg::opLsb]);

   always_comb
   begin
      // Everything off unless the opcode asks for it
      ctrl    = '0;
      ctrl.aluOp   = procPkg::aluPass;
      ctrl.immKind = procPkg::imm6Signed;
      illegal = 1'b0;
      case (opcode)
         procPkg::opNop:
         begin
         end
         procPkg::opAdd, procPkg::opSub, procPkg::opAnd, procPkg::opXor:
         begin
            ctrl.regWrite = 1'b1;
            case (opcode)
               procPkg::opAdd: ctrl.aluOp = procPkg::aluAdd;
               procPkg::opSub: ctrl.aluOp = procPkg::aluSub;
               procPkg::opAnd: ctrl.aluOp = procPkg::aluAnd;
               default:        ctrl.aluOp = procPkg::aluXor;
            endcase
         end
         procPkg::opAddi:
         begin
            ctrl.regWrite  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp     = procPkg::aluAdd;
         end
         procPkg::opLbi:
         begin
            ctrl.regWrite  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            ctrl.immKind   = procPkg::imm9Signed;
         end
         procPkg::opSlbi:
         begin
            ctrl.regWrite  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp     = procPkg::aluShiftOr;
            ctrl.immKind   = procPkg::imm9Low8;
         end
         procPkg::opLd:
         begin
            ctrl.regWrite  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp     = procPkg::aluAdd;
            ctrl.memRead   = 1'b1;
            ctrl.memToReg  = 1'b1;
         end
         procPkg::opSt:
         begin
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp     = procPkg::aluAdd;
            ctrl.memWrite  = 1'b1;
         end
         procPkg::opBeqz:
         begin
            ctrl.branchZero = 1'b1;
            ctrl.immKind    = procPkg::imm9Signed;
         end
         procPkg::opBnez:
         begin
            ctrl.branchNonZero = 1'b1;
            ctrl.immKind       = procPkg::imm9Signed;
         end
         procPkg::opJ:
         begin
            ctrl.jump    = 1'b1;
            ctrl.immKind = procPkg::imm12Signed;
         end
         procPkg::opHalt:
         begin
            ctrl.halt = 1'b1;
         end
         // Unused encodings stop the core without side effects
         procPkg::opIll14, procPkg::opIll15:
         begin
            ctrl.halt = 1'b1;
            illegal   = 1'b1;
         end
         default:
         begin
            ctrl.halt = 1'b1;
            illegal   = 1'b1;
         end
      endcase
   end

   assign stop = ctrl.halt;

   // Sticky error flag
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         err <= 1'b0;
      end
      else if (illegal)
      begin
         err <= 1'b1;
      end
   end

endmodule

/* verilog/fetch.sv */
module fetch (
   input  logic                           clk,
   input  logic                           rst,
   input  procPkg::loadT                  load,
   input  logic [procPkg::dataWidth-1:0]  nextPc,
   input  logic                           stop,
   output logic [procPkg::dataWidth-1:0]  pc,
   output logic [procPkg::dataWidth-1:0]  instr,
   output logic                           halted
);

   logic [procPkg::dataWidth-1:0] imem [procPkg::imemDepth];
   logic [procPkg::imemAddrWidth-1:0] fetchAddr;

   // Program image is written while the core sits in reset
   always_ff @(posedge clk)
   begin
      if (rst && load.en)
      begin
         imem[load.addr] <= load.data;
      end
   end

   // Only the low address bits reach the instruction memory
   assign fetchAddr = pc[procPkg::imemAddrWidth-1:0];
   assign instr     = imem[fetchAddr];

   // PC holds on the halting instruction and stays there
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc <= '0;
      end
      else if (!halted && !stop)
      begin
         pc <= nextPc;
      end
   end

   // Halt latch, cleared only by reset
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         halted <= 1'b0;
      end
      else if (stop)
      begin
         halted <= 1'b1;
      end
   end

endmodule

/* verilog/procPkg.sv */
package procPkg;

   // Datapath and storage sizes
   localparam int dataWidth     = 16;
   localparam int regCount      = 8;
   localparam int regIdxWidth   = $clog2(regCount);
   localparam int imemDepth     = 256;
   localparam int dmemDepth     = 256;
   localparam int imemAddrWidth = $clog2(imemDepth);
   localparam int dmemAddrWidth = $clog2(dmemDepth);

   // Instruction field positions
   localparam int opMsb    = 15;
   localparam int opLsb    = 12;
   localparam int rdMsb    = 11;
   localparam int rdLsb    = 9;
   localparam int rsMsb    = 8;
   localparam int rsLsb    = 6;
   localparam int rtMsb    = 5;
   localparam int rtLsb    = 3;
   localparam int imm6Msb  = 5;
   localparam int imm9Msb  = 8;
   localparam int imm12Msb = 11;

   typedef enum logic [3:0] {
      opNop   = 4'd0,
      opAdd   = 4'd1,
      opSub   = 4'd2,
      opAnd   = 4'd3,
      opXor   = 4'd4,
      opAddi  = 4'd5,
      opLbi   = 4'd6,
      opSlbi  = 4'd7,
      opLd    = 4'd8,
      opSt    = 4'd9,
      opBeqz  = 4'd10,
      opBnez  = 4'd11,
      opJ     = 4'd12,
      opHalt  = 4'd13,
      opIll14 = 4'd14,
      opIll15 = 4'd15
   } opcodeT;

   // PASS forwards the second operand
   typedef enum logic [2:0] {
      aluPass,
      aluAdd,
      aluSub,
      aluAnd,
      aluXor,
      aluShiftOr
   } aluOpT;

   typedef enum logic [1:0] {
      imm6Signed,
      imm9Signed,
      imm9Low8,
      imm12Signed
   } immKindT;

   typedef struct packed {
      logic    regWrite;
      logic    aluSrcImm;
      aluOpT   aluOp;
      logic    memRead;
      logic    memWrite;
      logic    memToReg;
      logic    branchZero;
      logic    branchNonZero;
      logic    jump;
      logic    halt;
      immKindT immKind;
   } ctrlT;

   // Program load port, honored only during reset
   typedef struct packed {
      logic                     en;
      logic [imemAddrWidth-1:0] addr;
      logic [dataWidth-1:0]     data;
   } loadT;

   typedef struct packed {
      logic                   valid;
      logic [dataWidth-1:0]   pc;
      logic                   regWrite;
      logic [regIdxWidth-1:0] wrReg;
      logic [dataWidth-1:0]   wrData;
   } retireT;

endpackage
